// ==== Bender.yml ====
package:
  name: frontEndBuffer

sources:
  - target: any(simulation, synthesis)
    files:
      - source/frontPkg.sv
      - source/instQueueRam.sv
      - source/instBuffer.sv
      - source/bufferCsr.sv
      - source/frontEndTop.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/instBufferTb.sv

// ==== dv/axiLiteTasks.svh ====
////////////////////////////////////////
// call 2 ns after a rising edge, one transaction at a time
////////////////////////////////////////

// address and data together, then wait for the response
task automatic axiWrite(input logic [frontPkg::csrAddrWidth-1:0] addr,
                        input logic [frontPkg::csrDataWidth-1:0] data,
                        output logic [1:0] resp);
  int waitCycles;
  awaddr_i = addr;
  wdata_i = data;
  wstrb_i = '1;
  awvalid_i = 1'b1;
  wvalid_i = 1'b1;
  waitCycles = 0;
  do begin
    @(negedge clk);
    waitCycles++;
    if (waitCycles > 20) failRun("AXI write address and data were never accepted");
  end while (!(awready_o && wready_o));
  // handshake completes at this edge
  @(posedge clk);
  #2;
  awvalid_i = 1'b0;
  wvalid_i = 1'b0;
  bready_i = 1'b1;
  waitCycles = 0;
  do begin
    @(negedge clk);
    waitCycles++;
    if (waitCycles > 20) failRun("AXI write response never arrived");
  end while (!bvalid_o);
  resp = bresp_o;
  @(posedge clk);
  #2;
  bready_i = 1'b0;
endtask

task automatic axiRead(input logic [frontPkg::csrAddrWidth-1:0] addr,
                       output logic [frontPkg::csrDataWidth-1:0] data,
                       output logic [1:0] resp);
  int waitCycles;
  araddr_i = addr;
  arvalid_i = 1'b1;
  waitCycles = 0;
  do begin
    @(negedge clk);
    waitCycles++;
    if (waitCycles > 20) failRun("AXI read address was never accepted");
  end while (!arready_o);
  @(posedge clk);
  #2;
  arvalid_i = 1'b0;
  rready_i = 1'b1;
  waitCycles = 0;
  do begin
    @(negedge clk);
    waitCycles++;
    if (waitCycles > 20) failRun("AXI read data never arrived");
  end while (!rvalid_o);
  data = rdata_o;
  resp = rresp_o;
  @(posedge clk);
  #2;
  rready_i = 1'b0;
endtask

// ==== dv/instBufferTb.sv ====
////////////////////////////////////////
// inputs driven 2 ns after the rising edge, outputs sampled at the falling edge
////////////////////////////////////////
`timescale 1ns/100ps

module instBufferTb;

  logic clk;
  logic reset_i;
  logic decodeReady_i;
  logic [frontPkg::fetchWidth-1:0] decodedVector_i;
  logic [frontPkg::fetchWidth-1:0][frontPkg::packetWidth-1:0] decodedPacket_i;
  logic stallFetch_o;
  logic instBufferReady_o;
  logic [frontPkg::dispatchWidth-1:0][frontPkg::packetWidth-1:0] decodedPacket_o;
  logic [frontPkg::branchCountWidth-1:0] branchCount_o;
  logic stall_i;
  logic flush_i;
  logic [frontPkg::csrAddrWidth-1:0] awaddr_i;
  logic awvalid_i;
  logic awready_o;
  logic [frontPkg::csrDataWidth-1:0] wdata_i;
  logic [frontPkg::csrStrbWidth-1:0] wstrb_i;
  logic wvalid_i;
  logic wready_o;
  logic [1:0] bresp_o;
  logic bvalid_o;
  logic bready_i;
  logic [frontPkg::csrAddrWidth-1:0] araddr_i;
  logic arvalid_i;
  logic arready_o;
  logic [frontPkg::csrDataWidth-1:0] rdata_o;
  logic [1:0] rresp_o;
  logic rvalid_o;
  logic rready_i;

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////
  // stored packets, oldest first
  logic [frontPkg::packetWidth-1:0] modelQ[$];
  logic holdModel;
  // flush pulse expected in the current cycle
  logic swFlushModel;
  logic [frontPkg::counterWidth-1:0] dispTotal;
  logic [frontPkg::counterWidth-1:0] brTotal;
  logic [31:0] lcgState;
  logic [frontPkg::csrDataWidth-1:0] rdData;
  logic [1:0] resp;

  frontEndTop dut_i (.*);

  always #20 clk = ~clk;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkPacket(input string name, input logic [frontPkg::packetWidth-1:0] got,
                             input logic [frontPkg::packetWidth-1:0] exp);
    if (got !== exp) failRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic checkCount(input string name, input logic [frontPkg::queueLog:0] got,
                            input logic [frontPkg::queueLog:0] exp);
    if (got !== exp) failRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic checkWord(input string name, input logic [frontPkg::csrDataWidth-1:0] got,
                           input logic [frontPkg::csrDataWidth-1:0] exp);
    if (got !== exp) failRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) failRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) failRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  `include "axiLiteTasks.svh"

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  // branch flags among the four oldest packets
  function automatic logic [frontPkg::queueLog:0] headBranches();
    logic [frontPkg::queueLog:0] n;
    n = '0;
    for (int i = 0; i < frontPkg::dispatchWidth; i++) begin
      n += modelQ[i][frontPkg::branchBit];
    end
    return n;
  endfunction

  function automatic bit dispatchExpected();
    return modelQ.size() >= frontPkg::dispatchWidth && !stall_i && !holdModel
           && !flush_i && !swFlushModel;
  endfunction

  // one clock edge: flush first, then dispatch from head, then packed writes at tail
  function automatic void refStep(input bit fire);
    bit ctrlWrite;
    bit full;
    ctrlWrite = awready_o && awaddr_i == frontPkg::ctrlAddr && wstrb_i[0];
    full = modelQ.size() > frontPkg::stallLimit;
    if (flush_i || swFlushModel) begin
      modelQ.delete();
    end else begin
      if (fire) begin
        dispTotal += frontPkg::dispatchWidth;
        brTotal += headBranches();
        repeat (frontPkg::dispatchWidth) void'(modelQ.pop_front());
      end
      if (decodeReady_i && !full) begin
        for (int k = 0; k < frontPkg::fetchWidth; k++) begin
          if (decodedVector_i[k]) modelQ.push_back(decodedPacket_i[k]);
        end
      end
    end
    // register write lands at this edge, flush pulse one cycle later
    swFlushModel = ctrlWrite && wdata_i[frontPkg::flushBit];
    if (ctrlWrite) holdModel = wdata_i[frontPkg::holdBit];
  endfunction

  ////////////////////////////////////////
  // comparison at every falling edge
  ////////////////////////////////////////
  always @(negedge clk) begin : compareEdge
    bit fire;
    if (reset_i) begin
      modelQ.delete();
      holdModel = 1'b0;
      swFlushModel = 1'b0;
      dispTotal = '0;
      brTotal = '0;
    end else begin
      checkFlag("instBufferReady_o", instBufferReady_o, modelQ.size() >= frontPkg::dispatchWidth);
      checkFlag("stallFetch_o", stallFetch_o, modelQ.size() > frontPkg::stallLimit);
      fire = dispatchExpected();
      // group at head leaves at the coming edge
      if (fire) begin
        for (int r = 0; r < frontPkg::dispatchWidth; r++) begin
          checkPacket($sformatf("decodedPacket_o[%0d]", r), decodedPacket_o[r], modelQ[r]);
        end
        checkCount("branchCount_o", branchCount_o, headBranches());
      end
      refStep(fire);
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  // dense groups fill fast, sparse ones leave gaps between slots
  task automatic newGroup(input bit dense);
    logic [31:0] r;
    r = nextRand();
    decodedVector_i = dense ? (r[23:16] | r[31:24]) : (r[23:16] & r[31:24]);
    for (int k = 0; k < frontPkg::fetchWidth; k++) begin
      decodedPacket_i[k] = nextRand();
    end
  endtask

  task automatic runDecode(input int cycles, input bit stallHigh, input bit dense);
    bit held;
    logic [31:0] r;
    held = 1'b0;
    repeat (cycles) begin
      if (!held) newGroup(dense);
      r = nextRand();
      decodeReady_i = 1'b1;
      stall_i = stallHigh | (r[31:30] == 2'b00);
      // a stalled group stays on the bus for the next cycle
      @(negedge clk);
      held = stallFetch_o;
      @(posedge clk);
      #2;
    end
    decodeReady_i = 1'b0;
  endtask

  // one full group while dispatch is stalled
  task automatic fillGroup();
    newGroup(1'b1);
    decodedVector_i = '1;
    decodeReady_i = 1'b1;
    stall_i = 1'b1;
    @(posedge clk);
    #2;
    decodeReady_i = 1'b0;
  endtask

  task automatic drainBuffer();
    int waitCycles;
    stall_i = 1'b0;
    decodeReady_i = 1'b0;
    waitCycles = 0;
    do begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles > 40) failRun("buffer never drained below one dispatch group");
    end while (instBufferReady_o);
    @(posedge clk);
    #2;
  endtask

  initial begin
    lcgState = 32'h6921;
    reset_i = 1'b1;
    clk = 1'b0;
    decodeReady_i = 1'b0;
    decodedVector_i = '0;
    decodedPacket_i = '0;
    stall_i = 1'b0;
    flush_i = 1'b0;
    awaddr_i = '0;
    awvalid_i = 1'b0;
    wdata_i = '0;
    wstrb_i = '0;
    wvalid_i = 1'b0;
    bready_i = 1'b0;
    araddr_i = '0;
    arvalid_i = 1'b0;
    rready_i = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    reset_i = 1'b0;

    // in-order delivery of sparse groups
    runDecode(80, 1'b0, 1'b0);
    drainBuffer();

    // back-pressure until fetch stalls, then release
    runDecode(16, 1'b1, 1'b1);
    checkFlag("stallFetch_o", stallFetch_o, 1'b1);
    runDecode(30, 1'b0, 1'b0);
    drainBuffer();

    // misprediction flush
    runDecode(4, 1'b1, 1'b1);
    flush_i = 1'b1;
    @(posedge clk);
    #2;
    flush_i = 1'b0;
    checkFlag("instBufferReady_o", instBufferReady_o, 1'b0);
    axiRead(frontPkg::occAddr, rdData, resp);
    checkCount("occupancy", rdData[frontPkg::queueLog:0], '0);
    runDecode(12, 1'b0, 1'b0);
    drainBuffer();

    // hold bit freezes head with ready high
    fillGroup();
    axiWrite(frontPkg::ctrlAddr, 32'h1, resp);
    checkResp("bresp_o", resp, frontPkg::axiOkay);
    stall_i = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    checkFlag("instBufferReady_o", instBufferReady_o, 1'b1);
    axiRead(frontPkg::occAddr, rdData, resp);
    checkCount("occupancy", rdData[frontPkg::queueLog:0], modelQ.size());
    axiWrite(frontPkg::ctrlAddr, 32'h0, resp);
    drainBuffer();

    // software flush, self-clearing
    fillGroup();
    axiWrite(frontPkg::ctrlAddr, 32'h2, resp);
    checkResp("bresp_o", resp, frontPkg::axiOkay);
    axiRead(frontPkg::ctrlAddr, rdData, resp);
    checkWord("control register", rdData, '0);
    axiRead(frontPkg::occAddr, rdData, resp);
    checkCount("occupancy", rdData[frontPkg::queueLog:0], '0);
    runDecode(10, 1'b0, 1'b0);
    drainBuffer();

    // statistics and status
    stall_i = 1'b1;
    axiRead(frontPkg::occAddr, rdData, resp);
    checkCount("occupancy", rdData[frontPkg::queueLog:0], modelQ.size());
    axiRead(frontPkg::dispCntAddr, rdData, resp);
    checkWord("dispatched counter", rdData, dispTotal);
    checkResp("rresp_o", resp, frontPkg::axiOkay);
    axiRead(frontPkg::brCntAddr, rdData, resp);
    checkWord("branch counter", rdData, brTotal);
    axiWrite(frontPkg::occAddr, 32'hFFFF, resp);
    checkResp("bresp_o", resp, frontPkg::axiOkay);
    axiWrite(4'h6, 32'h0, resp);
    checkResp("bresp_o", resp, frontPkg::axiSlvErr);
    axiRead(4'h6, rdData, resp);
    checkResp("rresp_o", resp, frontPkg::axiSlvErr);
    checkWord("rdata_o", rdData, '0);

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+dv
source/frontPkg.sv
source/instQueueRam.sv
source/instBuffer.sv
source/bufferCsr.sv
source/frontEndTop.sv
dv/instBufferTb.sv

// ==== source/bufferCsr.sv ====
////////////////////////////////////////
// one AXI4-Lite transaction per channel at a time
// counters clear on reset only, not on flush
////////////////////////////////////////
`timescale 1ns/100ps

module bufferCsr (
  input  logic clk,
  input  logic reset_i,

  // AXI4-Lite slave
  input  logic [frontPkg::csrAddrWidth-1:0] awaddr_i,
  input  logic awvalid_i,
  output logic awready_o,
  input  logic [frontPkg::csrDataWidth-1:0] wdata_i,
  input  logic [frontPkg::csrStrbWidth-1:0] wstrb_i,
  input  logic wvalid_i,
  output logic wready_o,
  output logic [1:0] bresp_o,
  output logic bvalid_o,
  input  logic bready_i,
  input  logic [frontPkg::csrAddrWidth-1:0] araddr_i,
  input  logic arvalid_i,
  output logic arready_o,
  output logic [frontPkg::csrDataWidth-1:0] rdata_o,
  output logic [1:0] rresp_o,
  output logic rvalid_o,
  input  logic rready_i,

  // buffer side
  output logic holdDispatch_o,
  output logic swFlush_o,
  input  logic [frontPkg::queueLog:0] instCount_i,
  input  logic dispatchFire_i,
  input  logic [frontPkg::branchCountWidth-1:0] branchCount_i
);

  logic writeAccept;
  logic readAccept;
  logic ctrlWrite;
  logic [frontPkg::counterWidth-1:0] dispCount;
  logic [frontPkg::counterWidth-1:0] brCount;

  ////////////////////////////////////////
  // write channel
  ////////////////////////////////////////
  // awready and wready pulse together for one cycle
  assign awready_o = writeAccept;
  assign wready_o = writeAccept;
  // only byte 0 of the control word carries bits
  assign ctrlWrite = writeAccept & (awaddr_i == frontPkg::ctrlAddr) & wstrb_i[0];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      writeAccept <= 1'b0;
      bvalid_o <= 1'b0;
      holdDispatch_o <= 1'b0;
      swFlush_o <= 1'b0;
    end else begin
      writeAccept <= awvalid_i & wvalid_i & ~bvalid_o & ~writeAccept;
      // flush pulse lives for the cycle after acceptance
      swFlush_o <= ctrlWrite & wdata_i[frontPkg::flushBit];
      if (ctrlWrite) begin
        holdDispatch_o <= wdata_i[frontPkg::holdBit];
      end
      if (writeAccept) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
    end
  end

  // read-only offsets swallow writes quietly
  always_ff @(posedge clk) begin
    if (writeAccept) begin
      bresp_o <= (awaddr_i inside {frontPkg::ctrlAddr, frontPkg::occAddr,
                                   frontPkg::dispCntAddr, frontPkg::brCntAddr})
                 ? frontPkg::axiOkay : frontPkg::axiSlvErr;
    end
  end

  ////////////////////////////////////////
  // read channel
  ////////////////////////////////////////
  assign arready_o = readAccept;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      readAccept <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      readAccept <= arvalid_i & ~rvalid_o & ~readAccept;
      if (readAccept) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  // flush bit always reads back as zero
  always_ff @(posedge clk) begin
    if (readAccept) begin
      rresp_o <= frontPkg::axiOkay;
      case (araddr_i)
        frontPkg::ctrlAddr: rdata_o <= {{(frontPkg::csrDataWidth-1){1'b0}}, holdDispatch_o};
        frontPkg::occAddr:
          rdata_o <= {{(frontPkg::csrDataWidth-frontPkg::queueLog-1){1'b0}}, instCount_i};
        frontPkg::dispCntAddr: rdata_o <= dispCount;
        frontPkg::brCntAddr: rdata_o <= brCount;
        default: begin
          rdata_o <= '0;
          rresp_o <= frontPkg::axiSlvErr;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // statistics
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      dispCount <= '0;
      brCount <= '0;
    end else if (dispatchFire_i) begin
      dispCount <= dispCount + (frontPkg::counterWidth)'(frontPkg::dispatchWidth);
      brCount <= brCount
               + {{(frontPkg::counterWidth-frontPkg::branchCountWidth){1'b0}}, branchCount_i};
    end
  end

endmodule

// ==== source/frontEndTop.sv ====
////////////////////////////////////////
// decode to dispatch buffer with its AXI4-Lite register block
////////////////////////////////////////
`timescale 1ns/100ps

module frontEndTop (
  input  logic clk,
  input  logic reset_i,

  // decode group
  input  logic decodeReady_i,
  input  logic [frontPkg::fetchWidth-1:0] decodedVector_i,
  input  logic [frontPkg::fetchWidth-1:0][frontPkg::packetWidth-1:0] decodedPacket_i,
  output logic stallFetch_o,

  // dispatch group
  output logic instBufferReady_o,
  output logic [frontPkg::dispatchWidth-1:0][frontPkg::packetWidth-1:0] decodedPacket_o,
  output logic [frontPkg::branchCountWidth-1:0] branchCount_o,
  input  logic stall_i,
  input  logic flush_i,

  // AXI4-Lite slave
  input  logic [frontPkg::csrAddrWidth-1:0] awaddr_i,
  input  logic awvalid_i,
  output logic awready_o,
  input  logic [frontPkg::csrDataWidth-1:0] wdata_i,
  input  logic [frontPkg::csrStrbWidth-1:0] wstrb_i,
  input  logic wvalid_i,
  output logic wready_o,
  output logic [1:0] bresp_o,
  output logic bvalid_o,
  input  logic bready_i,
  input  logic [frontPkg::csrAddrWidth-1:0] araddr_i,
  input  logic arvalid_i,
  output logic arready_o,
  output logic [frontPkg::csrDataWidth-1:0] rdata_o,
  output logic [1:0] rresp_o,
  output logic rvalid_o,
  input  logic rready_i
);

  // buffer to storage
  logic [frontPkg::fetchWidth-1:0] ramWriteEnable;
  logic [frontPkg::fetchWidth-1:0][frontPkg::queueLog-1:0] ramWriteAddr;
  logic [frontPkg::fetchWidth-1:0][frontPkg::packetWidth-1:0] ramWriteData;
  logic [frontPkg::dispatchWidth-1:0][frontPkg::queueLog-1:0] ramReadAddr;
  logic [frontPkg::dispatchWidth-1:0][frontPkg::packetWidth-1:0] ramReadData;
  // buffer to register block
  logic holdDispatch;
  logic swFlush;
  logic dispatchFire;
  logic [frontPkg::queueLog:0] instCount;

  instBuffer buffer_i (
    .clk(clk), .reset_i(reset_i), .flush_i(flush_i), .swFlush_i(swFlush),
    .holdDispatch_i(holdDispatch), .stall_i(stall_i), .decodeReady_i(decodeReady_i),
    .decodedVector_i(decodedVector_i), .decodedPacket_i(decodedPacket_i),
    .stallFetch_o(stallFetch_o), .instBufferReady_o(instBufferReady_o),
    .decodedPacket_o(decodedPacket_o), .branchCount_o(branchCount_o),
    .dispatchFire_o(dispatchFire), .instCount_o(instCount),
    .ramWriteEnable_o(ramWriteEnable), .ramWriteAddr_o(ramWriteAddr),
    .ramWriteData_o(ramWriteData), .ramReadAddr_o(ramReadAddr), .ramReadData_i(ramReadData)
  );

  instQueueRam ram_i (
    .clk(clk), .writeEnable_i(ramWriteEnable), .writeAddr_i(ramWriteAddr),
    .writeData_i(ramWriteData), .readAddr_i(ramReadAddr), .readData_o(ramReadData)
  );

  // branch count feeds both dispatch and the branch counter
  bufferCsr csr_i (
    .clk(clk), .reset_i(reset_i),
    .awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
    .wdata_i(wdata_i), .wstrb_i(wstrb_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
    .bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
    .araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
    .rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
    .holdDispatch_o(holdDispatch), .swFlush_o(swFlush), .instCount_i(instCount),
    .dispatchFire_i(dispatchFire), .branchCount_i(branchCount_o)
  );

endmodule

// ==== source/frontPkg.sv ====
////////////////////////////////////////
// all sizes fixed here, modules take none as parameters
// packet is opaque except for the branch flag in its top bit
////////////////////////////////////////
package frontPkg;

  ////////////////////////////////////////
  // buffer geometry
  ////////////////////////////////////////
  // decode slots per cycle
  localparam int fetchWidth = 8;
  // packets per dispatch group
  localparam int dispatchWidth = 4;
  localparam int queueDepth = 32;
  localparam int queueLog = 5;
  localparam int packetWidth = 32;
  // branch flag position inside a packet
  localparam int branchBit = 31;
  // a full fetch group still fits at or below this occupancy
  localparam int stallLimit = queueDepth - fetchWidth;
  // up to four branches in a group
  localparam int branchCountWidth = 3;
  localparam int counterWidth = 32;

  ////////////////////////////////////////
  // register block
  ////////////////////////////////////////
  localparam int csrAddrWidth = 4;
  localparam int csrDataWidth = 32;
  localparam int csrStrbWidth = csrDataWidth / 8;
  localparam logic [csrAddrWidth-1:0] ctrlAddr = 4'h0;
  localparam logic [csrAddrWidth-1:0] occAddr = 4'h4;
  localparam logic [csrAddrWidth-1:0] dispCntAddr = 4'h8;
  localparam logic [csrAddrWidth-1:0] brCntAddr = 4'hC;
  // control register bits
  localparam int holdBit = 0;
  localparam int flushBit = 1;
  localparam logic [1:0] axiOkay = 2'b00;
  localparam logic [1:0] axiSlvErr = 2'b10;

endpackage

// ==== source/instBuffer.sv ====
////////////////////////////////////////
// decode must hold its group while stallFetch_o is high
// flush beats write and dispatch in the same cycle
////////////////////////////////////////
`timescale 1ns/100ps

module instBuffer (
  input  logic clk,
  input  logic reset_i,
  // misprediction flush and the register block pulse
  input  logic flush_i,
  input  logic swFlush_i,
  input  logic holdDispatch_i,
  // back-pressure from later stages
  input  logic stall_i,

  // decode group
  input  logic decodeReady_i,
  input  logic [frontPkg::fetchWidth-1:0] decodedVector_i,
  input  logic [frontPkg::fetchWidth-1:0][frontPkg::packetWidth-1:0] decodedPacket_i,
  output logic stallFetch_o,

  // dispatch group
  output logic instBufferReady_o,
  output logic [frontPkg::dispatchWidth-1:0][frontPkg::packetWidth-1:0] decodedPacket_o,
  output logic [frontPkg::branchCountWidth-1:0] branchCount_o,
  output logic dispatchFire_o,
  output logic [frontPkg::queueLog:0] instCount_o,

  // storage ports
  output logic [frontPkg::fetchWidth-1:0] ramWriteEnable_o,
  output logic [frontPkg::fetchWidth-1:0][frontPkg::queueLog-1:0] ramWriteAddr_o,
  output logic [frontPkg::fetchWidth-1:0][frontPkg::packetWidth-1:0] ramWriteData_o,
  output logic [frontPkg::dispatchWidth-1:0][frontPkg::queueLog-1:0] ramReadAddr_o,
  input  logic [frontPkg::dispatchWidth-1:0][frontPkg::packetWidth-1:0] ramReadData_i
);

  // circular queue pointers
  logic [frontPkg::queueLog-1:0] headPtr;
  logic [frontPkg::queueLog-1:0] tailPtr;
  // live packets, one bit wider to hold a full queue
  logic [frontPkg::queueLog:0] instCount;
  logic [frontPkg::queueLog:0] nextCount;
  logic [frontPkg::queueLog:0] writeCount;
  logic [frontPkg::branchCountWidth-1:0] branchSum;
  logic flushAll;
  logic stallFetch;
  logic writeGo;
  logic dispatchFire;

  assign flushAll = flush_i | swFlush_i;

  ////////////////////////////////////////
  // fetch side
  ////////////////////////////////////////
  // room for a full group only at or below the limit
  assign stallFetch = (instCount > frontPkg::stallLimit);
  assign stallFetch_o = stallFetch;
  assign writeGo = decodeReady_i & ~stallFetch;

  // pack valid slots onto consecutive entries from tail
  // slot k goes to tail plus valid slots below k
  always_comb begin
    writeCount = '0;
    for (int k = 0; k < frontPkg::fetchWidth; k++) begin
      ramWriteEnable_o[k] = writeGo & decodedVector_i[k];
      ramWriteAddr_o[k] = tailPtr + writeCount[frontPkg::queueLog-1:0];
      writeCount = writeCount + {{frontPkg::queueLog{1'b0}}, ramWriteEnable_o[k]};
    end
  end

  // data follows its own slot, the address does the packing
  assign ramWriteData_o = decodedPacket_i;

  ////////////////////////////////////////
  // dispatch side
  ////////////////////////////////////////
  assign instBufferReady_o = (instCount >= frontPkg::dispatchWidth);
  // group leaves when ready, not stalled, not held, no flush
  assign dispatchFire = instBufferReady_o & ~stall_i & ~holdDispatch_i & ~flushAll;
  assign dispatchFire_o = dispatchFire;

  // four lanes from head, count branch flags among them
  always_comb begin
    branchSum = '0;
    for (int r = 0; r < frontPkg::dispatchWidth; r++) begin
      ramReadAddr_o[r] = headPtr + (frontPkg::queueLog)'(r);
      branchSum = branchSum
                + {{(frontPkg::branchCountWidth-1){1'b0}}, ramReadData_i[r][frontPkg::branchBit]};
    end
  end

  assign decodedPacket_o = ramReadData_i;
  assign branchCount_o = branchSum;

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////
  // writes and dispatch may both happen at one edge
  always_comb begin
    nextCount = instCount + writeCount;
    if (dispatchFire) begin
      nextCount = nextCount - (frontPkg::queueLog + 1)'(frontPkg::dispatchWidth);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || flushAll) begin
      headPtr <= '0;
      tailPtr <= '0;
      instCount <= '0;
    end else begin
      // pointers wrap naturally at queueDepth
      tailPtr <= tailPtr + writeCount[frontPkg::queueLog-1:0];
      if (dispatchFire) begin
        headPtr <= headPtr + (frontPkg::queueLog)'(frontPkg::dispatchWidth);
      end
      instCount <= nextCount;
    end
  end

  assign instCount_o = instCount;

endmodule

// ==== source/instQueueRam.sv ====
////////////////////////////////////////
// write addresses of one cycle must differ, no reset on contents
////////////////////////////////////////
`timescale 1ns/100ps

module instQueueRam (
  input  logic clk,

  // write side, one port per decode slot
  input  logic [frontPkg::fetchWidth-1:0] writeEnable_i,
  input  logic [frontPkg::fetchWidth-1:0][frontPkg::queueLog-1:0] writeAddr_i,
  input  logic [frontPkg::fetchWidth-1:0][frontPkg::packetWidth-1:0] writeData_i,

  // read side, one port per dispatch lane
  input  logic [frontPkg::dispatchWidth-1:0][frontPkg::queueLog-1:0] readAddr_i,
  output logic [frontPkg::dispatchWidth-1:0][frontPkg::packetWidth-1:0] readData_o
);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  // occupancy in the buffer decides which entries hold live packets
  logic [frontPkg::packetWidth-1:0] queueMem [frontPkg::queueDepth];

  ////////////////////////////////////////
  // write ports
  ////////////////////////////////////////
  // compacted slots land on distinct consecutive entries
  // so port order does not matter here
  always_ff @(posedge clk) begin
    for (int p = 0; p < frontPkg::fetchWidth; p++) begin
      if (writeEnable_i[p]) begin
        queueMem[writeAddr_i[p]] <= writeData_i[p];
      end
    end
  end

  ////////////////////////////////////////
  // read ports
  ////////////////////////////////////////
  // asynchronous read
  // entry written at an edge shows up right after it
  always_comb begin
    for (int r = 0; r < frontPkg::dispatchWidth; r++) begin
      // lane r looks at head plus r
      readData_o[r] = queueMem[readAddr_i[r]];
    end
  end

endmodule
